/* filelist.f */
src/tunnel_pkg.sv
src/vga_timing.sv
src/scene_control.sv
src/tunnel_frame_draw.sv
src/diagonal_draw.sv
src/score_draw.sv
src/frame_score_top.sv
testbench/frame_score_properties.sv
testbench/frame_score_tb.sv

/* testbench/frame_score_tb.sv */
// testbench for the tunnel backdrop; scans whole frames and compares every pixel with a model
module frame_score_tb import tunnel_pkg::*;;

	localparam int cell_x1 = 64;
	localparam int cell_x2 = 544;
	localparam int cell_y = 10;
	localparam int frame_cycles = h_total * v_total;
	// six scanned frames plus reset and pipeline fill
	localparam int frames_run = 6;
	localparam int cycle_limit = frames_run * frame_cycles + 1000;
	// requests change inside the score rows to catch tearing
	localparam int change_row = 20;

	// tunnel corners, outer to inner
	localparam int frame_ul_x [9] = '{63, 132, 171, 197, 215, 229, 239, 247, 255};
	localparam int frame_ul_y [9] = '{47, 99, 128, 148, 161, 171, 179, 185, 191};
	localparam int frame_w [9] = '{514, 376, 297, 245, 209, 182, 162, 145, 130};
	localparam int frame_h [9] = '{386, 283, 223, 185, 157, 137, 122, 109, 98};
	localparam int diag_x1 [4] = '{63, 384, 255, 576};
	localparam int diag_y1 [4] = '{47, 288, 288, 47};
	localparam int diag_x2 [4] = '{255, 576, 63, 384};
	localparam int diag_y2 [4] = '{191, 432, 432, 191};
	localparam bit diag_fall [4] = '{1'b0, 1'b0, 1'b1, 1'b1};
	// segments a..g in bits 6..0
	localparam logic [6:0] digit_segs [10] = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33,
		7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h7b};

	logic clk;
	logic rst;
	game_mode_t mode_req;
	logic [15:0] your_score;
	logic [15:0] their_score;
	rgb_t color;
	logic hsync;
	logic vsync;
	pixel_pos_t out_pos;
	scene_t exp_scene;
	int ex = 0;
	int ey = 0;
	int cycles = 0;

	frame_score_top #(.score_x1(cell_x1), .score_x2(cell_x2), .score_y(cell_y)) u_dut (
		.clk(clk), .rst(rst), .mode_req(mode_req), .your_score(your_score),
		.their_score(their_score), .color(color), .hsync(hsync), .vsync(vsync),
		.out_pos(out_pos)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit) begin
			$display("timeout: the run went past its cycle limit");
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

	always @(negedge clk) begin
		if (u_dut.props.failures != 0) begin
			$display("a bound assertion on the DUT outputs failed");
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

	// legal edges only, digits are the low nibble modulo 10
	function automatic scene_t next_scene(scene_t cur, game_mode_t req, logic [15:0] ys,
			logic [15:0] ts);
		scene_t s;
		s = cur;
		if (cur.mode == mode_attract && req == mode_play) begin
			s.mode = mode_play;
		end else if (cur.mode == mode_play && req == mode_over) begin
			s.mode = mode_over;
		end else if (cur.mode == mode_over && req != mode_play && req != mode_over) begin
			s.mode = mode_attract;
		end
		s.your_digit = 4'(ys[3:0] % 10);
		s.their_digit = 4'(ts[3:0] % 10);
		return s;
	endfunction

	function automatic bit on_frame(int x, int y);
		int lx;
		int ly;
		for (int i = 0; i < 9; i++) begin
			lx = frame_ul_x[i] + frame_w[i] - 1;
			ly = frame_ul_y[i] + frame_h[i] - 1;
			if ((y == frame_ul_y[i] || y == ly) && x >= frame_ul_x[i] && x <= lx)
				return 1'b1;
			if ((x == frame_ul_x[i] || x == lx) && y >= frame_ul_y[i] && y <= ly)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// row k starts k + k/3 from the corner, third rows are 3 wide
	function automatic bit on_diagonal(int x, int y);
		int k;
		int w;
		int first;
		int last;
		for (int d = 0; d < 4; d++) begin
			if (y >= diag_y1[d] && y <= diag_y2[d]) begin
				k = y - diag_y1[d];
				w = (k % 3 == 2) ? 3 : 2;
				first = diag_fall[d] ? diag_x1[d] - (k + k / 3) - w + 1 : diag_x1[d] + k + k / 3;
				last = first + w - 1;
				if (x >= first && x <= last && x >= diag_x1[d] && x <= diag_x2[d])
					return 1'b1;
				if (x >= first && x <= last && x >= diag_x2[d] && x <= diag_x1[d])
					return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic bit on_score(int x, int y, scene_t s);
		int col;
		int row;
		logic [6:0] segs;
		if (y < cell_y || y >= cell_y + 32)
			return 1'b0;
		row = y - cell_y;
		if (x >= cell_x1 && x < cell_x1 + 32) begin
			col = x - cell_x1;
			segs = digit_segs[s.your_digit];
		end else if (x >= cell_x2 && x < cell_x2 + 32) begin
			col = x - cell_x2;
			segs = digit_segs[s.their_digit];
		end else begin
			return 1'b0;
		end
		return (segs[6] && row <= 3) || (segs[5] && col >= 28 && row <= 17) ||
			(segs[4] && col >= 28 && row >= 14) || (segs[3] && row >= 28) ||
			(segs[2] && col <= 3 && row >= 14) || (segs[1] && col <= 3 && row <= 17) ||
			(segs[0] && row >= 14 && row <= 17);
	endfunction

	function automatic rgb_t ref_color(int x, int y, scene_t s);
		rgb_t line_color;
		line_color = (s.mode == mode_play) ? pal_green :
			(s.mode == mode_over) ? pal_red : pal_gray;
		if (x >= h_active || y >= v_active)
			return pal_black;
		if (on_frame(x, y) || on_diagonal(x, y))
			return line_color;
		if (s.mode == mode_play && on_score(x, y, s))
			return pal_teal;
		if (s.mode == mode_over && on_score(x, y, s))
			return pal_white;
		return pal_black;
	endfunction

	function automatic pixel_pos_t expected_pos(int x, int y);
		pixel_pos_t p;
		p.x = coord_t'(x);
		p.y = coord_t'(y);
		p.active = (x < h_active) && (y < v_active);
		p.line_end = (x == h_active - 1);
		p.frame_start = (x == h_total - 1) && (y == v_total - 1);
		return p;
	endfunction

	task automatic check_color(rgb_t got, rgb_t exp, int x, int y);
		if (got !== exp) begin
			$display("** Error: color = %h, expected %h at x=%0d y=%0d", got, exp, x, y);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_pos(pixel_pos_t got, pixel_pos_t exp);
		if (got !== exp) begin
			$display("** Error: out_pos = %h, expected %h", got, exp);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_sync(string name, logic got, logic exp, int x, int y);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h at x=%0d y=%0d", name, got, exp, x, y);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	// one output frame from (0,0), new request driven at change_row
	task automatic check_frame(game_mode_t req, logic [15:0] ys, logic [15:0] ts);
		for (int i = 0; i < frame_cycles; i++) begin
			check_pos(out_pos, expected_pos(ex, ey));
			check_sync("hsync", hsync, !(ex >= h_sync_start && ex < h_sync_end), ex, ey);
			check_sync("vsync", vsync, !(ey >= v_sync_start && ey < v_sync_end), ex, ey);
			check_color(color, ref_color(ex, ey, exp_scene), ex, ey);
			if (ex == 0 && ey == change_row) begin
				mode_req = req;
				your_score = ys;
				their_score = ts;
			end
			// the DUT samples the request at the next rising edge
			if (ex == h_total - 3 && ey == v_total - 1)
				exp_scene = next_scene(exp_scene, mode_req, your_score, their_score);
			ex = (ex == h_total - 1) ? 0 : ex + 1;
			if (ex == 0)
				ey = (ey == v_total - 1) ? 0 : ey + 1;
			@(negedge clk);
		end
	endtask

	task automatic test_reset_and_timing();
		rst = 1'b1;
		repeat (16) @(negedge clk);
		check_color(color, pal_black, 0, 0);
		check_sync("hsync", hsync, 1'b1, 0, 0);
		check_sync("vsync", vsync, 1'b1, 0, 0);
		rst = 1'b0;
		// fixed latency of two, out_pos now shows the first pixel
		repeat (2) @(negedge clk);
	endtask

	task automatic test_attract_and_diagonals();
		check_frame(mode_over, 16'd3, 16'd7);
	endtask

	task automatic test_illegal_request();
		check_frame(mode_play, 16'd3, 16'd7);
	endtask

	task automatic test_play_scores();
		check_frame(mode_play, 16'd12, 16'd9);
		check_frame(mode_over, 16'd12, 16'd9);
	endtask

	task automatic test_game_over();
		check_frame(mode_attract, 16'd12, 16'd9);
		check_frame(mode_attract, 16'd12, 16'd9);
	endtask

	initial begin
		rst = 1'b1;
		mode_req = mode_attract;
		your_score = '0;
		their_score = '0;
		exp_scene.mode = mode_attract;
		exp_scene.your_digit = '0;
		exp_scene.their_digit = '0;
		test_reset_and_timing();
		test_attract_and_diagonals();
		test_illegal_request();
		test_play_scores();
		test_game_over();
		if (u_dut.props.failures == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

endmodule

/* testbench/frame_score_properties.sv */
// concurrent checks on output sync, frame strobe and blanking color; bound into the top level
module frame_score_properties import tunnel_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       hsync,
	input rgb_t       color,
	input pixel_pos_t out_pos
);

	// read by the testbench monitor
	int unsigned failures = 0;

	hsync_window: assert property (@(posedge clk) disable iff (rst)
		!hsync |-> (out_pos.x >= coord_t'(h_sync_start)) && (out_pos.x < coord_t'(h_sync_end)))
	else begin
		failures++;
		$error("hsync low outside columns 656..751");
	end

	frame_start_pulse: assert property (@(posedge clk) disable iff (rst)
		out_pos.frame_start |=> !out_pos.frame_start)
	else begin
		failures++;
		$error("frame_start high for more than one cycle");
	end

	blank_is_black: assert property (@(posedge clk) disable iff (rst)
		!out_pos.active |-> color == pal_black)
	else begin
		failures++;
		$error("color not black outside the active area");
	end

endmodule

bind frame_score_top frame_score_properties props (
	.clk(clk), .rst(rst), .hsync(hsync), .color(color), .out_pos(out_pos)
);

/* src/frame_score_top.sv */
// tunnel backdrop top; timing, scene FSM and draw blocks merged into a registered color, latency 2
module frame_score_top import tunnel_pkg::*; #(
	parameter int score_x1 = 64,
	parameter int score_x2 = 544,
	parameter int score_y = 10
) (
	input  logic        clk,
	input  logic        rst,
	input  game_mode_t  mode_req,
	input  logic [15:0] your_score,
	input  logic [15:0] their_score,
	output rgb_t        color,
	output logic        hsync,
	output logic        vsync,
	output pixel_pos_t  out_pos
);

	// outer to inner
	localparam int frame_ul_x [9] = '{63, 132, 171, 197, 215, 229, 239, 247, 255};
	localparam int frame_ul_y [9] = '{47, 99, 128, 148, 161, 171, 179, 185, 191};
	localparam int frame_x_len [9] = '{514, 376, 297, 245, 209, 182, 162, 145, 130};
	localparam int frame_y_len [9] = '{386, 283, 223, 185, 157, 137, 122, 109, 98};

	pixel_pos_t pos;
	pixel_pos_t pos_d1;
	logic hsync_raw;
	logic vsync_raw;
	logic hsync_d1;
	logic vsync_d1;
	scene_t scene;
	logic [8:0] frame_draw;
	logic [3:0] diag_draw;
	logic score_hit;
	draw_hits_t hits;
	rgb_t line_color;
	rgb_t color_next;

	vga_timing timing (
		.clk(clk), .rst(rst), .pos(pos), .hsync(hsync_raw), .vsync(vsync_raw)
	);

	scene_control control (
		.clk(clk), .rst(rst), .pos(pos), .mode_req(mode_req),
		.your_score(your_score), .their_score(their_score), .scene(scene)
	);

	for (genvar i = 0; i < 9; i++) begin : g_frame
		tunnel_frame_draw #(
			.ul_x(frame_ul_x[i]), .ul_y(frame_ul_y[i]),
			.x_len(frame_x_len[i]), .y_len(frame_y_len[i])
		) frame (
			.clk(clk), .rst(rst), .pos(pos), .draw(frame_draw[i])
		);
	end

	diagonal_draw #(.x1(63), .y1(47), .x2(255), .y2(191), .falling(1'b0)) diag_ul (
		.clk(clk), .rst(rst), .pos(pos), .draw(diag_draw[0])
	);
	diagonal_draw #(.x1(384), .y1(288), .x2(576), .y2(432), .falling(1'b0)) diag_lr (
		.clk(clk), .rst(rst), .pos(pos), .draw(diag_draw[1])
	);
	diagonal_draw #(.x1(255), .y1(288), .x2(63), .y2(432), .falling(1'b1)) diag_ll (
		.clk(clk), .rst(rst), .pos(pos), .draw(diag_draw[2])
	);
	diagonal_draw #(.x1(576), .y1(47), .x2(384), .y2(191), .falling(1'b1)) diag_ur (
		.clk(clk), .rst(rst), .pos(pos), .draw(diag_draw[3])
	);

	score_draw #(.cell_x1(score_x1), .cell_x2(score_x2), .cell_y(score_y)) score (
		.clk(clk), .rst(rst), .pos(pos), .scene(scene), .draw(score_hit)
	);

	assign hits.frame = |frame_draw;
	assign hits.diag = |diag_draw;
	assign hits.score = score_hit;

	// scene flips while pos_d1 is still in blanking, so no mode delay is needed here
	always_comb begin
		case (scene.mode)
			mode_play: line_color = pal_green;
			mode_over: line_color = pal_red;
			default: line_color = pal_gray;
		endcase
		color_next = pal_black;
		if (pos_d1.active) begin
			if (hits.frame || hits.diag) begin
				color_next = line_color;
			end else if (hits.score && scene.mode == mode_play) begin
				color_next = pal_teal;
			end else if (hits.score && scene.mode == mode_over) begin
				color_next = pal_white;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pos_d1 <= '0;
			hsync_d1 <= 1'b1;
			vsync_d1 <= 1'b1;
			out_pos <= '0;
			color <= pal_black;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			pos_d1 <= pos;
			hsync_d1 <= hsync_raw;
			vsync_d1 <= vsync_raw;
			out_pos <= pos_d1;
			color <= color_next;
			hsync <= hsync_d1;
			vsync <= vsync_d1;
		end
	end

endmodule

/* src/score_draw.sv */
// seven-segment renderer for the two 32x32 score cells; picks the digit by cell, hit registered
module score_draw import tunnel_pkg::*; #(
	parameter int cell_x1 = 64,
	parameter int cell_x2 = 544,
	parameter int cell_y = 10
) (
	input  logic       clk,
	input  logic       rst,
	input  pixel_pos_t pos,
	input  scene_t     scene,
	output logic       draw
);

	localparam int cell_size = 32;

	logic in_rows;
	logic in_cell1;
	logic in_cell2;
	coord_t dx;
	coord_t dy;
	logic [4:0] col;
	logic [4:0] row;
	logic [3:0] digit;
	logic [6:0] seg;
	logic seg_hit;

	// {g,f,e,d,c,b,a}
	function automatic logic [6:0] seg_decode(input logic [3:0] value);
		case (value)
			4'd0: return 7'h3f;
			4'd1: return 7'h06;
			4'd2: return 7'h5b;
			4'd3: return 7'h4f;
			4'd4: return 7'h66;
			4'd5: return 7'h6d;
			4'd6: return 7'h7d;
			4'd7: return 7'h07;
			4'd8: return 7'h7f;
			4'd9: return 7'h6f;
			default: return 7'h00;
		endcase
	endfunction

	assign in_rows = (pos.y >= cell_y) && (pos.y < cell_y + cell_size);
	assign in_cell1 = (pos.x >= cell_x1) && (pos.x < cell_x1 + cell_size);
	assign in_cell2 = (pos.x >= cell_x2) && (pos.x < cell_x2 + cell_size);

	// offsets within whichever cell is hit
	assign dx = in_cell1 ? pos.x - coord_t'(cell_x1) : pos.x - coord_t'(cell_x2);
	assign dy = pos.y - coord_t'(cell_y);
	assign col = dx[4:0];
	assign row = dy[4:0];

	assign digit = in_cell1 ? scene.your_digit : scene.their_digit;
	assign seg = seg_decode(digit);

	// 4 pixel bars; verticals overlap the middle bar
	always_comb begin
		seg_hit = 1'b0;
		seg_hit |= seg[0] && (row <= 5'd3);
		seg_hit |= seg[1] && (col >= 5'd28) && (row <= 5'd17);
		seg_hit |= seg[2] && (col >= 5'd28) && (row >= 5'd14);
		seg_hit |= seg[3] && (row >= 5'd28);
		seg_hit |= seg[4] && (col <= 5'd3) && (row >= 5'd14);
		seg_hit |= seg[5] && (col <= 5'd3) && (row <= 5'd17);
		seg_hit |= seg[6] && (row >= 5'd14) && (row <= 5'd17);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			draw <= 1'b0;
		end else begin
			draw <= in_rows && (in_cell1 || in_cell2) && seg_hit;
		end
	end

endmodule

/* src/diagonal_draw.sv */
// stepped diagonal for one tunnel edge; start column advances 1,1,2 per three lines, hit registered
module diagonal_draw import tunnel_pkg::*; #(
	parameter int x1 = 63,
	parameter int y1 = 47,
	parameter int x2 = 255,
	parameter int y2 = 191,
	// 0 steps right, 1 steps left
	parameter bit falling = 1'b0
) (
	input  logic       clk,
	input  logic       rst,
	input  pixel_pos_t pos,
	output logic       draw
);

	localparam int box_left = falling ? x2 : x1;
	localparam int box_right = falling ? x1 : x2;

	coord_t x_start;
	logic [1:0] cnt3;
	coord_t step;
	logic in_rows;
	logic in_box;
	logic on_line;

	// every third line steps by 2 and is drawn one pixel wider
	assign step = (cnt3 == 2'd2) ? coord_t'(2) : coord_t'(1);

	assign in_rows = (pos.y >= y1) && (pos.y <= y2);
	assign in_box = in_rows && (pos.x >= box_left) && (pos.x <= box_right);

	always_comb begin
		if (falling) begin
			on_line = (pos.x <= x_start) && (pos.x >= x_start - step);
		end else begin
			on_line = (pos.x >= x_start) && (pos.x <= x_start + step);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			x_start <= coord_t'(x1);
			cnt3 <= '0;
		end else if (pos.line_end) begin
			if (pos.y == coord_t'(y1 - 1)) begin
				// rearm on the line above the edge
				x_start <= coord_t'(x1);
				cnt3 <= '0;
			end else if (in_rows) begin
				if (falling) begin
					x_start <= x_start - step;
				end else begin
					x_start <= x_start + step;
				end
				if (cnt3 == 2'd2) begin
					cnt3 <= '0;
				end else begin
					cnt3 <= cnt3 + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			draw <= 1'b0;
		end else begin
			draw <= in_box && on_line;
		end
	end

endmodule

/* src/tunnel_frame_draw.sv */
// one-pixel rectangle outline hit test; one instance per tunnel frame, hit registered
module tunnel_frame_draw import tunnel_pkg::*; #(
	parameter int ul_x = 63,
	parameter int ul_y = 47,
	parameter int x_len = 514,
	parameter int y_len = 386
) (
	input  logic       clk,
	input  logic       rst,
	input  pixel_pos_t pos,
	output logic       draw
);

	localparam int lr_x = ul_x + x_len - 1;
	localparam int lr_y = ul_y + y_len - 1;

	logic in_cols;
	logic in_rows;
	logic on_edge_row;
	logic on_edge_col;

	assign in_cols = (pos.x >= ul_x) && (pos.x <= lr_x);
	assign in_rows = (pos.y >= ul_y) && (pos.y <= lr_y);
	assign on_edge_row = (pos.y == coord_t'(ul_y)) || (pos.y == coord_t'(lr_y));
	assign on_edge_col = (pos.x == coord_t'(ul_x)) || (pos.x == coord_t'(lr_x));

	always_ff @(posedge clk) begin
		if (rst) begin
			draw <= 1'b0;
		end else begin
			draw <= (on_edge_row && in_cols) || (on_edge_col && in_rows);
		end
	end

endmodule

/* src/scene_control.sv */
// game mode FSM; samples mode request and score digits only at frame start so a frame never tears
module scene_control import tunnel_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  pixel_pos_t pos,
	input  game_mode_t mode_req,
	input  logic [15:0] your_score,
	input  logic [15:0] their_score,
	output scene_t     scene
);

	typedef enum logic [1:0] {
		st_attract,
		st_play,
		st_over
	} state_t;

	state_t state;
	state_t state_next;
	logic [3:0] your_digit;
	logic [3:0] their_digit;

	// low nibble folded into 0..9
	function automatic logic [3:0] fold_digit(input logic [3:0] value);
		if (value >= 4'd10) begin
			return value - 4'd10;
		end
		return value;
	endfunction

	// only attract->play->over->attract; anything else holds
	always_comb begin
		state_next = state;
		case (state)
			st_attract: begin
				if (mode_req == mode_play) begin
					state_next = st_play;
				end
			end
			st_play: begin
				if (mode_req == mode_over) begin
					state_next = st_over;
				end
			end
			st_over: begin
				// reserved code counts as attract
				if (mode_req != mode_play && mode_req != mode_over) begin
					state_next = st_attract;
				end
			end
			default: state_next = st_attract;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_attract;
			your_digit <= '0;
			their_digit <= '0;
		end else if (pos.frame_start) begin
			state <= state_next;
			your_digit <= fold_digit(your_score[3:0]);
			their_digit <= fold_digit(their_score[3:0]);
		end
	end

	always_comb begin
		case (state)
			st_play: scene.mode = mode_play;
			st_over: scene.mode = mode_over;
			default: scene.mode = mode_attract;
		endcase
		scene.your_digit = your_digit;
		scene.their_digit = their_digit;
	end

endmodule

/* src/vga_timing.sv */
// raster generator for 800x525 timing; drives the pixel position bus and both syncs, all registered
module vga_timing import tunnel_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	output pixel_pos_t pos,
	output logic       hsync,
	output logic       vsync
);

	coord_t x_next;
	coord_t y_next;
	logic active_next;
	logic line_end_next;
	logic frame_start_next;
	logic hsync_next;
	logic vsync_next;

	// counters wrap at 799 and 524
	always_comb begin
		x_next = pos.x + 1'b1;
		y_next = pos.y;
		if (pos.x == coord_t'(h_total - 1)) begin
			x_next = '0;
			if (pos.y == coord_t'(v_total - 1)) begin
				y_next = '0;
			end else begin
				y_next = pos.y + 1'b1;
			end
		end
	end

	// strobes decoded one step ahead so they line up with the registered position
	always_comb begin
		active_next = (x_next < h_active) && (y_next < v_active);
		line_end_next = (x_next == coord_t'(h_active - 1));
		frame_start_next = (x_next == coord_t'(h_total - 1)) &&
			(y_next == coord_t'(v_total - 1));
		hsync_next = !((x_next >= h_sync_start) && (x_next < h_sync_end));
		vsync_next = !((y_next >= v_sync_start) && (y_next < v_sync_end));
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pos.x <= '0;
			pos.y <= '0;
			// (0,0) is a visible pixel
			pos.active <= 1'b1;
			pos.line_end <= 1'b0;
			pos.frame_start <= 1'b0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			pos.x <= x_next;
			pos.y <= y_next;
			pos.active <= active_next;
			pos.line_end <= line_end_next;
			pos.frame_start <= frame_start_next;
			hsync <= hsync_next;
			vsync <= vsync_next;
		end
	end

endmodule

/* src/tunnel_pkg.sv */
// shared raster constants, mode encoding, palette and bus structs; imported by every design module
package tunnel_pkg;

	// 640x480 at 800x525 total
	localparam int h_active = 640;
	localparam int h_total = 800;
	localparam int v_active = 480;
	localparam int v_total = 525;

	// sync windows, start inclusive, end exclusive, pulses active low
	localparam int h_sync_start = 656;
	localparam int h_sync_end = 752;
	localparam int v_sync_start = 490;
	localparam int v_sync_end = 492;

	typedef logic [15:0] coord_t;
	typedef logic [23:0] rgb_t;

	localparam rgb_t pal_black = 24'h000000;
	localparam rgb_t pal_green = 24'h00ff00;
	localparam rgb_t pal_red = 24'hff0000;
	localparam rgb_t pal_gray = 24'hd3d3d3;
	localparam rgb_t pal_teal = 24'h66ffff;
	localparam rgb_t pal_white = 24'hffffff;

	// code 3 is reserved and behaves as attract
	typedef enum logic [1:0] {
		mode_attract = 2'd0,
		mode_play = 2'd1,
		mode_over = 2'd2
	} game_mode_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		logic active;
		logic line_end;
		logic frame_start;
	} pixel_pos_t;

	typedef struct packed {
		game_mode_t mode;
		logic [3:0] your_digit;
		logic [3:0] their_digit;
	} scene_t;

	typedef struct packed {
		logic frame;
		logic diag;
		logic score;
	} draw_hits_t;

endpackage
